/* tb.f */
+incdir+common
common/riders_pkg.sv
src/riders_dpram.sv
src/riders_main_bus.sv
prot/riders_prot.sv
src/riders_sound_comm.sv
src/riders_game.sv
bench/riders_game_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= riders_game_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/riders_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/riders_game_tb.sv */
// Self-checking bench for the game core; APB and sound CPU drivers only, one transfer at a time
`timescale 1ns/1ps
`include "riders_settings.svh"

module riders_game_tb;
    import riders_pkg::*;

    localparam int wram_words = 1 << `RIDERS_WRAM_AW;
    localparam int max_blk    = 64;
    localparam int n_ram      = 16;
    localparam int n_dma      = 32;
    localparam int n_busy     = 40;
    // Rough cycle cost of each test with 4 to 5 cycles per APB transfer
    localparam int est_cycles = 10 + (n_ram * 10 + 30) + (n_dma * 10 + 40) +
                                (n_busy * 5 + 80) + 60;
    localparam int limit_cycles = 4 * est_cycles;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;
    logic        prot_irq;
    logic        snd_irq;
    logic        snd_rd;
    logic [7:0]  snd_dout;
    logic        snd_wr;
    logic [7:0]  snd_din;

    logic [31:0] rng_state = 32'd94869;
    int          cycles = 0;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_clean;
    int          test_errors;
    word_t       wram_model [0:wram_words-1];

    riders_game dut_i (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .paddr    ( paddr    ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .prot_irq ( prot_irq ),
        .snd_irq  ( snd_irq  ),
        .snd_rd   ( snd_rd   ),
        .snd_dout ( snd_dout ),
        .snd_wr   ( snd_wr   ),
        .snd_din  ( snd_din  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit_cycles) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic word_t rand_word();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    function automatic logic [15:0] wram_byte(input int waddr);
        return `RIDERS_WRAM_BASE + 16'(waddr * 2);
    endfunction

    function automatic logic [15:0] oram_byte(input int waddr);
        return `RIDERS_ORAM_BASE + 16'(waddr * 2);
    endfunction

    function automatic logic [15:0] prot_addr(input logic [2:0] off);
        return `RIDERS_PROT_BASE | {13'd0, off};
    endfunction

    function automatic logic [15:0] snd_addr(input logic [2:0] off);
        return `RIDERS_SND_BASE | {13'd0, off};
    endfunction

    // Expected status word with busy in bit 15, irq in bit 14 and the kept count below
    function automatic word_t stat_word(input logic busy, input logic irq, input int kept);
        word_t w;
        w     = 16'(kept);
        w[15] = busy;
        w[14] = irq;
        return w;
    endfunction

    // Keeps visible entries in order and packs them from index 0
    function automatic int ref_compact(input word_t src_words [0:max_blk-1], input int n,
                                       output obj_entry_t kept_list [0:max_blk-1]);
        obj_entry_t e;
        int         k;
        int         i;
        k = 0;
        for (i = 0; i < max_blk; i++) begin
            kept_list[i] = '0;
        end
        for (i = 0; i < n; i++) begin
            e = obj_entry_t'(src_words[i]);
            if (e.visible) begin
                kept_list[k] = e;
                k++;
            end
        end
        return k;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_entry(input obj_entry_t got, input obj_entry_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is v=%b p=%0d c=%h, expected v=%b p=%0d c=%h",
                     $time, what, got.visible, got.prio, got.code,
                     exp.visible, exp.prio, exp.code);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One APB transfer; outputs sampled on the falling edge
    task automatic apb_xfer(input logic wr, input logic [15:0] addr, input word_t wdata,
                            output word_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input word_t data, output logic err);
        word_t unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [15:0] addr, output word_t data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic begin_test();
        test_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_clean++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - test_errors);
        end
    endtask

    task automatic ram_test();
        int    addr_list [0:n_ram-1];
        word_t data;
        word_t rd;
        logic  err;
        int    i;
        begin_test();
        check_flag(pready, 1'b0, "pready after reset");
        check_flag(pslverr, 1'b0, "pslverr after reset");
        check_flag(prot_irq, 1'b0, "prot_irq after reset");
        check_flag(snd_irq, 1'b0, "snd_irq after reset");
        for (i = 0; i < n_ram; i++) begin
            addr_list[i] = int'(rand_word()) % wram_words;
            data         = rand_word();
            apb_write(wram_byte(addr_list[i]), data, err);
            check_flag(err, 1'b0, "pslverr on work RAM write");
            wram_model[addr_list[i]] = data;
        end
        for (i = 0; i < n_ram; i++) begin
            apb_read(wram_byte(addr_list[i]), rd, err);
            check_flag(err, 1'b0, "pslverr on work RAM read");
            check_word(rd, wram_model[addr_list[i]], "work RAM word");
        end
        apb_write(`RIDERS_ORAM_BASE, 16'h1234, err);
        check_flag(err, 1'b1, "pslverr on object RAM write");
        apb_read(16'h5000, rd, err);
        check_flag(err, 1'b1, "pslverr on unmapped read");
        apb_write(16'h1400, 16'h0055, err);
        check_flag(err, 1'b1, "pslverr on unmapped write");
        end_test("work RAM and decode");
    endtask

    task automatic dma_test();
        word_t      src_words [0:max_blk-1];
        obj_entry_t exp_list [0:max_blk-1];
        int         src;
        int         exp_kept;
        int         lat;
        int         i;
        word_t      rd;
        logic       err;
        begin_test();
        src = 64 + int'(rand_word()) % 512;
        for (i = 0; i < max_blk; i++) begin
            src_words[i] = (i < n_dma) ? rand_word() : '0;
        end
        for (i = 0; i < n_dma; i++) begin
            apb_write(wram_byte(src + i), src_words[i], err);
        end
        exp_kept = ref_compact(src_words, n_dma, exp_list);
        apb_write(prot_addr(`RIDERS_PROT_SRC), 16'(src), err);
        apb_write(prot_addr(`RIDERS_PROT_CNT), 16'(n_dma), err);
        apb_write(prot_addr(`RIDERS_PROT_CTRL), 16'h0001, err);
        check_flag(err, 1'b0, "pslverr on DMA start");
        // Count cycles from the start write to the interrupt
        lat = 1;
        @(negedge clk);
        while (!prot_irq) begin
            @(negedge clk);
            lat++;
        end
        check_word(16'(lat), 16'(n_dma + 2), "cycles from start to prot_irq");
        apb_read(prot_addr(`RIDERS_PROT_STAT), rd, err);
        check_word(rd, stat_word(1'b0, 1'b1, exp_kept), "status after DMA");
        for (i = 0; i < exp_kept; i++) begin
            apb_read(oram_byte(i), rd, err);
            check_entry(obj_entry_t'(rd), exp_list[i], "object RAM entry");
        end
        end_test("protection DMA");
    endtask

    task automatic busy_test();
        word_t      src_words [0:max_blk-1];
        obj_entry_t exp_list [0:max_blk-1];
        int         src;
        int         exp_kept;
        int         i;
        word_t      rd;
        logic       err;
        begin_test();
        apb_write(prot_addr(`RIDERS_PROT_STAT), 16'h0000, err);
        @(negedge clk);
        check_flag(prot_irq, 1'b0, "prot_irq after status write");
        src = 1200 + int'(rand_word()) % 256;
        for (i = 0; i < max_blk; i++) begin
            src_words[i] = (i < n_busy) ? rand_word() : '0;
        end
        for (i = 0; i < n_busy; i++) begin
            apb_write(wram_byte(src + i), src_words[i], err);
        end
        exp_kept = ref_compact(src_words, n_busy, exp_list);
        apb_write(prot_addr(`RIDERS_PROT_SRC), 16'(src), err);
        apb_write(prot_addr(`RIDERS_PROT_CNT), 16'(n_busy), err);
        apb_write(prot_addr(`RIDERS_PROT_CTRL), 16'h0001, err);
        apb_read(wram_byte(src), rd, err);
        check_flag(err, 1'b1, "pslverr on work RAM read while busy");
        // A short count that a wrongly accepted restart would pick up
        apb_write(prot_addr(`RIDERS_PROT_CNT), 16'h0001, err);
        apb_write(prot_addr(`RIDERS_PROT_CTRL), 16'h0001, err);
        check_flag(err, 1'b1, "pslverr on start while busy");
        apb_read(prot_addr(`RIDERS_PROT_STAT), rd, err);
        check_flag(rd[15], 1'b1, "busy bit during DMA");
        while (!prot_irq) begin
            @(negedge clk);
        end
        apb_read(prot_addr(`RIDERS_PROT_STAT), rd, err);
        check_word(rd, stat_word(1'b0, 1'b1, exp_kept), "status after rejected start");
        end_test("DMA busy handling");
    endtask

    task automatic mailbox_tx_test();
        word_t data;
        word_t rd;
        logic  err;
        begin_test();
        data = rand_word();
        apb_write(snd_addr(`RIDERS_SND_TX), data, err);
        @(negedge clk);
        check_flag(snd_irq, 1'b1, "snd_irq after TX write");
        check_word(16'(snd_dout), {8'h00, data[7:0]}, "snd_dout");
        apb_read(snd_addr(`RIDERS_SND_STAT), rd, err);
        check_word(rd, 16'h0002, "mailbox status with byte unread");
        @(posedge clk);
        snd_rd <= 1'b1;
        @(posedge clk);
        snd_rd <= 1'b0;
        @(negedge clk);
        check_flag(snd_irq, 1'b0, "snd_irq after snd_rd");
        end_test("mailbox to sound CPU");
    endtask

    task automatic mailbox_rx_test();
        word_t data;
        word_t rd;
        logic  err;
        begin_test();
        data = rand_word();
        @(posedge clk);
        snd_wr  <= 1'b1;
        snd_din <= data[7:0];
        @(posedge clk);
        snd_wr <= 1'b0;
        apb_read(snd_addr(`RIDERS_SND_STAT), rd, err);
        check_word(rd, 16'h0001, "mailbox status with reply pending");
        apb_read(snd_addr(`RIDERS_SND_RX), rd, err);
        check_word(rd, {8'h00, data[7:0]}, "reply byte");
        apb_read(snd_addr(`RIDERS_SND_STAT), rd, err);
        check_word(rd, 16'h0000, "mailbox status after RX read");
        end_test("mailbox from sound CPU");
    endtask

    initial begin
        arst_n      <= 1'b1;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= '0;
        pwdata      <= '0;
        snd_rd      <= 1'b0;
        snd_wr      <= 1'b0;
        snd_din     <= '0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        tests_clean = 0;
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        ram_test();
        dma_test();
        busy_test();
        mailbox_tx_test();
        mailbox_rx_test();
        $display("Summary: %0d of %0d tests clean, %0d checks, %0d errors",
                 tests_clean, tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/riders_game.sv */
// Game core top; video, audio, ROM loading and EEPROM live outside this core
`timescale 1ns/1ps
`include "riders_settings.svh"

module riders_game (
    input  logic              clk,
    input  logic              arst_n,
    // Main CPU over APB
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [15:0]       paddr,
    input  riders_pkg::word_t pwdata,
    output riders_pkg::word_t prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              prot_irq,
    // Sound CPU
    output logic              snd_irq,
    input  logic              snd_rd,
    output logic [7:0]        snd_dout,
    input  logic              snd_wr,
    input  logic [7:0]        snd_din
);
    import riders_pkg::*;

    logic                       wram_we;
    logic [`RIDERS_WRAM_AW-1:0] wram_waddr;
    logic [`RIDERS_WRAM_AW-1:0] wram_raddr;
    word_t                      wram_wdata;
    word_t                      wram_rdata;
    logic                       cpu_wram_re;
    logic                       oram_we;
    logic [`RIDERS_ORAM_AW-1:0] oram_waddr;
    logic [`RIDERS_ORAM_AW-1:0] oram_raddr;
    obj_entry_t                 oram_wdata;
    obj_entry_t                 oram_rdata;
    logic                       prot_cs;
    logic                       snd_cs;
    logic                       reg_we;
    logic                       reg_re;
    logic [`RIDERS_REG_AW-1:0]  reg_addr;
    word_t                      reg_wdata;
    word_t                      prot_rdata;
    word_t                      snd_rdata;
    logic                       prot_busy;

    riders_main_bus bus_i (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .psel        ( psel        ),
        .penable     ( penable     ),
        .pwrite      ( pwrite      ),
        .paddr       ( paddr       ),
        .pwdata      ( pwdata      ),
        .prdata      ( prdata      ),
        .pready      ( pready      ),
        .pslverr     ( pslverr     ),
        .wram_we     ( wram_we     ),
        .wram_waddr  ( wram_waddr  ),
        .wram_wdata  ( wram_wdata  ),
        .cpu_wram_re ( cpu_wram_re ),
        .wram_rdata  ( wram_rdata  ),
        .oram_raddr  ( oram_raddr  ),
        .oram_rdata  ( oram_rdata  ),
        .prot_cs     ( prot_cs     ),
        .snd_cs      ( snd_cs      ),
        .reg_we      ( reg_we      ),
        .reg_re      ( reg_re      ),
        .reg_addr    ( reg_addr    ),
        .reg_wdata   ( reg_wdata   ),
        .prot_rdata  ( prot_rdata  ),
        .snd_rdata   ( snd_rdata   ),
        .prot_busy   ( prot_busy   )
    );

    // CPU read address rides on the bus write address
    riders_prot prot_i (
        .clk            ( clk         ),
        .arst_n         ( arst_n      ),
        .prot_cs        ( prot_cs     ),
        .reg_we         ( reg_we      ),
        .reg_re         ( reg_re      ),
        .reg_addr       ( reg_addr    ),
        .reg_wdata      ( reg_wdata   ),
        .prot_rdata     ( prot_rdata  ),
        .cpu_wram_re    ( cpu_wram_re ),
        .cpu_wram_raddr ( wram_waddr  ),
        .wram_raddr     ( wram_raddr  ),
        .wram_rdata     ( wram_rdata  ),
        .oram_we        ( oram_we     ),
        .oram_waddr     ( oram_waddr  ),
        .oram_wdata     ( oram_wdata  ),
        .busy           ( prot_busy   ),
        .irq            ( prot_irq    )
    );

    riders_sound_comm snd_i (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .snd_cs    ( snd_cs    ),
        .reg_we    ( reg_we    ),
        .reg_re    ( reg_re    ),
        .reg_addr  ( reg_addr  ),
        .reg_wdata ( reg_wdata ),
        .snd_rdata ( snd_rdata ),
        .snd_irq   ( snd_irq   ),
        .snd_rd    ( snd_rd    ),
        .snd_dout  ( snd_dout  ),
        .snd_wr    ( snd_wr    ),
        .snd_din   ( snd_din   )
    );

    riders_dpram #(.data_t(word_t), .aw(`RIDERS_WRAM_AW)) wram_i (
        .clk   ( clk        ),
        .we    ( wram_we    ),
        .waddr ( wram_waddr ),
        .wdata ( wram_wdata ),
        .raddr ( wram_raddr ),
        .rdata ( wram_rdata )
    );

    riders_dpram #(.data_t(obj_entry_t), .aw(`RIDERS_ORAM_AW)) oram_i (
        .clk   ( clk        ),
        .we    ( oram_we    ),
        .waddr ( oram_waddr ),
        .wdata ( oram_wdata ),
        .raddr ( oram_raddr ),
        .rdata ( oram_rdata )
    );

endmodule

/* src/riders_sound_comm.sv */
// Byte mailbox between the CPUs; a new byte overwrites one that is still unread
`timescale 1ns/1ps
`include "riders_settings.svh"

module riders_sound_comm (
    input  logic                      clk,
    input  logic                      arst_n,
    // Main CPU side
    input  logic                      snd_cs,
    input  logic                      reg_we,
    input  logic                      reg_re,
    input  logic [`RIDERS_REG_AW-1:0] reg_addr,
    input  riders_pkg::word_t         reg_wdata,
    output riders_pkg::word_t         snd_rdata,
    // Sound CPU side
    output logic                      snd_irq,
    input  logic                      snd_rd,
    output logic [7:0]                snd_dout,
    input  logic                      snd_wr,
    input  logic [7:0]                snd_din
);
    import riders_pkg::*;

    logic [7:0] tx_q;
    logic [7:0] rx_q;
    logic       rx_pend;
    logic       tx_wr;
    logic       rx_rd;

    assign tx_wr    = snd_cs & reg_we & (reg_addr == `RIDERS_SND_TX);
    assign rx_rd    = snd_cs & reg_re & (reg_addr == `RIDERS_SND_RX);
    assign snd_dout = tx_q;

    // Byte latches
    always_ff @(posedge clk) begin
        if (tx_wr) begin
            tx_q <= reg_wdata[7:0];
        end
        if (snd_wr) begin
            rx_q <= snd_din;
        end
    end

    // A new byte wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_irq <= 1'b0;
            rx_pend <= 1'b0;
        end else begin
            if (tx_wr) begin
                snd_irq <= 1'b1;
            end else if (snd_rd) begin
                snd_irq <= 1'b0;
            end
            if (snd_wr) begin
                rx_pend <= 1'b1;
            end else if (rx_rd) begin
                rx_pend <= 1'b0;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            `RIDERS_SND_TX:   snd_rdata = word_t'(tx_q);
            `RIDERS_SND_RX:   snd_rdata = word_t'(rx_q);
            `RIDERS_SND_STAT: snd_rdata = word_t'({snd_irq, rx_pend});
            default:          snd_rdata = '0;
        endcase
    end

endmodule

/* prot/riders_prot.sv */
// Protection DMA; kept counts beyond the object RAM size wrap the write address
`timescale 1ns/1ps
`include "riders_settings.svh"

module riders_prot (
    input  logic                       clk,
    input  logic                       arst_n,
    // Register access
    input  logic                       prot_cs,
    input  logic                       reg_we,
    input  logic                       reg_re,
    input  logic [`RIDERS_REG_AW-1:0]  reg_addr,
    input  riders_pkg::word_t          reg_wdata,
    output riders_pkg::word_t          prot_rdata,
    // Work RAM read port shared with the CPU
    input  logic                       cpu_wram_re,
    input  logic [`RIDERS_WRAM_AW-1:0] cpu_wram_raddr,
    output logic [`RIDERS_WRAM_AW-1:0] wram_raddr,
    input  riders_pkg::word_t          wram_rdata,
    // Object RAM write port
    output logic                       oram_we,
    output logic [`RIDERS_ORAM_AW-1:0] oram_waddr,
    output riders_pkg::obj_entry_t     oram_wdata,
    output logic                       busy,
    output logic                       irq
);
    import riders_pkg::*;

    logic [`RIDERS_WRAM_AW-1:0] src;
    logic [`RIDERS_WRAM_AW-1:0] rd_ptr;
    logic [`RIDERS_WRAM_AW:0]   cnt;
    logic [`RIDERS_WRAM_AW:0]   left;
    logic [`RIDERS_WRAM_AW:0]   kept;
    logic                       rd_vld;
    logic                       wr_sel;
    logic                       start;
    logic                       done;
    obj_entry_t                 entry;

    assign wr_sel = prot_cs & reg_we;
    assign start  = wr_sel & ~busy & (reg_addr == `RIDERS_PROT_CTRL);
    assign done   = busy & (left == '0);

    // Work RAM words taken as object entries
    assign entry      = obj_entry_t'(wram_rdata);
    assign oram_we    = rd_vld & entry.visible;
    assign oram_waddr = kept[`RIDERS_ORAM_AW-1:0];
    assign oram_wdata = entry;

    // CPU gets the read port only when idle
    assign wram_raddr = (busy | ~cpu_wram_re) ? rd_ptr : cpu_wram_raddr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src    <= '0;
            cnt    <= '0;
            rd_ptr <= '0;
            left   <= '0;
            kept   <= '0;
            rd_vld <= 1'b0;
            busy   <= 1'b0;
            irq    <= 1'b0;
        end else begin
            // Data of a read issued now shows up next cycle
            rd_vld <= busy & (left != '0);
            if (wr_sel & (reg_addr == `RIDERS_PROT_SRC)) begin
                src <= reg_wdata[`RIDERS_WRAM_AW-1:0];
            end
            if (wr_sel & (reg_addr == `RIDERS_PROT_CNT)) begin
                cnt <= reg_wdata[`RIDERS_WRAM_AW:0];
            end
            if (wr_sel & (reg_addr == `RIDERS_PROT_STAT)) begin
                irq <= 1'b0;
            end
            if (start) begin
                busy   <= 1'b1;
                rd_ptr <= src;
                left   <= cnt;
                kept   <= '0;
            end else if (busy) begin
                if (done) begin
                    // Last entry is written on this same edge
                    busy <= 1'b0;
                    irq  <= 1'b1;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                    left   <= left - 1'b1;
                end
                if (oram_we) begin
                    kept <= kept + 1'b1;
                end
            end
        end
    end

    always_comb begin
        prot_rdata = '0;
        if (prot_cs & reg_re) begin
            case (reg_addr)
                `RIDERS_PROT_SRC: prot_rdata = word_t'(src);
                `RIDERS_PROT_CNT: prot_rdata = word_t'(cnt);
                `RIDERS_PROT_STAT: begin
                    prot_rdata     = word_t'(kept);
                    prot_rdata[15] = busy;
                    prot_rdata[14] = irq;
                end
                default: prot_rdata = '0;
            endcase
        end
    end

endmodule

/* src/riders_main_bus.sv */
// APB slave for the core; word accesses only, paddr[0] and byte lanes are ignored
`timescale 1ns/1ps
`include "riders_settings.svh"

module riders_main_bus (
    input  logic                       clk,
    input  logic                       arst_n,
    // APB
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [15:0]                paddr,
    input  riders_pkg::word_t          pwdata,
    output riders_pkg::word_t          prdata,
    output logic                       pready,
    output logic                       pslverr,
    // RAMs
    output logic                       wram_we,
    output logic [`RIDERS_WRAM_AW-1:0] wram_waddr,
    output riders_pkg::word_t          wram_wdata,
    output logic                       cpu_wram_re,
    input  riders_pkg::word_t          wram_rdata,
    output logic [`RIDERS_ORAM_AW-1:0] oram_raddr,
    input  riders_pkg::obj_entry_t     oram_rdata,
    // Register blocks
    output logic                       prot_cs,
    output logic                       snd_cs,
    output logic                       reg_we,
    output logic                       reg_re,
    output logic [`RIDERS_REG_AW-1:0]  reg_addr,
    output riders_pkg::word_t          reg_wdata,
    input  riders_pkg::word_t          prot_rdata,
    input  riders_pkg::word_t          snd_rdata,
    input  logic                       prot_busy
);
    import riders_pkg::*;

    localparam word_t wram_mask = ~word_t'((1 << (`RIDERS_WRAM_AW + 1)) - 1);
    localparam word_t oram_mask = ~word_t'((1 << (`RIDERS_ORAM_AW + 1)) - 1);
    localparam word_t reg_mask  = ~word_t'((1 << `RIDERS_REG_AW) - 1);

    region_t region;
    region_t region_q;
    logic    setup;
    logic    access;
    logic    done;
    logic    bad;
    logic    ram_rd;
    logic    wait_q;

    assign setup  = psel & ~penable;
    assign access = psel & penable;
    assign done   = access & pready & ~pslverr;

    // Address decode
    always_comb begin
        region = rgn_none;
        if ((paddr & wram_mask) == `RIDERS_WRAM_BASE) begin
            region = rgn_wram;
        end else if ((paddr & oram_mask) == `RIDERS_ORAM_BASE) begin
            region = rgn_oram;
        end else if ((paddr & reg_mask) == `RIDERS_PROT_BASE) begin
            region = rgn_prot;
        end else if ((paddr & reg_mask) == `RIDERS_SND_BASE) begin
            region = rgn_snd;
        end
    end

    // Error cases are judged in setup
    always_comb begin
        case (region)
            rgn_wram: bad = ~pwrite & prot_busy;
            rgn_oram: bad = pwrite;
            rgn_prot: bad = pwrite & prot_busy &
                            (paddr[`RIDERS_REG_AW-1:0] == `RIDERS_PROT_CTRL);
            rgn_snd:  bad = 1'b0;
            default:  bad = 1'b1;
        endcase
    end

    assign ram_rd = ~pwrite & ((region == rgn_wram) | (region == rgn_oram));

    // RAM reads get one wait state and everything else ends in the first access cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            region_q <= rgn_none;
            wait_q   <= 1'b0;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            if (setup) begin
                region_q <= region;
                wait_q   <= ram_rd & ~bad;
                pready   <= ~(ram_rd & ~bad);
                pslverr  <= bad;
            end else if (access & wait_q) begin
                wait_q <= 1'b0;
                pready <= 1'b1;
            end
        end
    end

    assign wram_we     = done & pwrite & (region_q == rgn_wram);
    assign wram_waddr  = paddr[`RIDERS_WRAM_AW:1];
    assign wram_wdata  = pwdata;
    assign cpu_wram_re = access & ~pwrite & (region_q == rgn_wram);
    assign oram_raddr  = paddr[`RIDERS_ORAM_AW:1];

    assign prot_cs   = region_q == rgn_prot;
    assign snd_cs    = region_q == rgn_snd;
    assign reg_we    = done & pwrite;
    assign reg_re    = done & ~pwrite;
    assign reg_addr  = paddr[`RIDERS_REG_AW-1:0];
    assign reg_wdata = pwdata;

    always_comb begin
        case (region_q)
            rgn_wram: prdata = wram_rdata;
            rgn_oram: prdata = word_t'(oram_rdata);
            rgn_prot: prdata = prot_rdata;
            rgn_snd:  prdata = snd_rdata;
            default:  prdata = '0;
        endcase
    end

endmodule

/* src/riders_dpram.sv */
// Simple dual-port RAM; a read of the address being written returns the old contents
`timescale 1ns/1ps

module riders_dpram #(
    parameter type data_t = logic [15:0],
    parameter int  aw     = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [aw-1:0] waddr,
    input  data_t         wdata,
    input  logic [aw-1:0] raddr,
    output data_t         rdata
);

    data_t mem [0:(1 << aw)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // One cycle read latency
        rdata <= mem[raddr];
    end

endmodule

/* common/riders_pkg.sv */
// Types shared by the core; all CPU data is 16 bits wide and object entries use that same width
package riders_pkg;

    // One CPU bus word
    typedef logic [15:0] word_t;

    // Object RAM entry, laid over a work-RAM word bit for bit
    typedef struct packed {
        logic        visible;
        logic [1:0]  prio;
        logic [12:0] code;
    } obj_entry_t;

    // Decoded CPU address regions
    typedef enum logic [2:0] {
        rgn_wram,
        rgn_oram,
        rgn_prot,
        rgn_snd,
        rgn_none
    } region_t;

endpackage

/* common/riders_settings.svh */
// Memory map and sizes; bases are byte addresses on a 16-bit bus and offsets fit a 3-bit window
`ifndef RIDERS_SETTINGS_SVH
`define RIDERS_SETTINGS_SVH

// Word address widths of the RAMs
`define RIDERS_WRAM_AW 11
`define RIDERS_ORAM_AW 9

// Byte offset width inside a register block
`define RIDERS_REG_AW 3

// Region bases
`define RIDERS_WRAM_BASE 16'h0000
`define RIDERS_ORAM_BASE 16'h1000
`define RIDERS_PROT_BASE 16'h2000
`define RIDERS_SND_BASE  16'h3000

// Protection registers
`define RIDERS_PROT_SRC  3'd0
`define RIDERS_PROT_CNT  3'd2
`define RIDERS_PROT_CTRL 3'd4
`define RIDERS_PROT_STAT 3'd6

// Sound mailbox registers
`define RIDERS_SND_TX   3'd0
`define RIDERS_SND_RX   3'd2
`define RIDERS_SND_STAT 3'd4

`endif
